// ==== l2_cache.f ====
verilog/l2_config_pkg.sv
verilog/l2_types_pkg.sv
verilog/sram_1r1w.sv
verilog/cache_lru.sv
verilog/l2_cache_tag.sv
verilog/l2_cache_read.sv
verilog/l2_cache_top.sv
verif/l2_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the L2 cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module l2_cache_tb \
	-f l2_cache.f \
	-o l2_cache_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/l2_cache_sim

// ==== verif/l2_cache_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module l2_cache_tb;
	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// One stimulus row with its expected response
	typedef struct {
		string name;
		logic valid;
		l2_op_t op;
		logic [31:0] addr;
		logic [31:0] data;
		logic exp_hit;
		// Expected load word taken from the recorded line instead of exp_data
		logic line_data;
		logic [31:0] exp_data;
		logic exp_wb;
		logic [31:0] exp_wb_addr;
	} test_row_t;

	// Response expected three falling edges after the row is driven
	typedef struct {
		string name;
		logic valid;
		l2_op_t op;
		logic exp_hit;
		logic check_data;
		logic [31:0] exp_data;
		logic exp_wb;
		logic [31:0] exp_wb_addr;
		logic [CACHE_LINE_BITS-1:0] exp_wb_line;
	} expect_t;

	logic clk;
	logic reset;
	l2req_packet_t request;
	l2_response_t response;

	test_row_t rows[$];
	expect_t pending[$];
	// Line contents the cache should hold keyed by line address
	logic [CACHE_LINE_BITS-1:0] shadow_lines [logic [31:0]];
	logic [31:0] lfsr_state;
	logic table_ready;

	l2_cache_top uut(
		.clk,
		.reset,
		.request,
		.response);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;

		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One step per bit of the line
	task automatic random_line(output logic [CACHE_LINE_BITS-1:0] line);
		for (int i = 0; i < CACHE_LINE_BITS; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			line[i] = lfsr_state[0];
		end
	endtask

	task automatic add_row(input string name, input logic valid, input l2_op_t op,
		input logic [31:0] addr, input logic [31:0] data, input logic exp_hit,
		input logic line_data, input logic [31:0] exp_data, input logic exp_wb,
		input logic [31:0] exp_wb_addr);
		test_row_t row;

		row.name = name;
		row.valid = valid;
		row.op = op;
		row.addr = addr;
		row.data = data;
		row.exp_hit = exp_hit;
		row.line_data = line_data;
		row.exp_data = exp_data;
		row.exp_wb = exp_wb;
		row.exp_wb_addr = exp_wb_addr;
		rows.push_back(row);
	endtask

	// Tag in bits 31:8 and set in bits 7:4 above the byte offset
	task automatic build_table();
		// Empty cache after reset
		add_row("reset_load_a", 1'b1, OP_LOAD, 32'h0000_1010, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("reset_load_b", 1'b1, OP_LOAD, 32'h0000_2234, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("idle_slot", 1'b0, OP_LOAD, 32'h0000_1010, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);

		// Fill one line in set 1 and read back every word
		add_row("fill_line", 1'b1, OP_FILL, 32'h0001_2310, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("load_word0", 1'b1, OP_LOAD, 32'h0001_2310, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		add_row("load_word1", 1'b1, OP_LOAD, 32'h0001_2314, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		add_row("load_word2", 1'b1, OP_LOAD, 32'h0001_2318, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		add_row("load_word3", 1'b1, OP_LOAD, 32'h0001_231c, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);

		// Store hits read back on the next cycle and after a gap
		add_row("store_word2", 1'b1, OP_STORE, 32'h0001_2318, 32'hcafe_0001, 1'b1, 1'b0,
			32'h0, 1'b0, 32'h0);
		add_row("load_after_store", 1'b1, OP_LOAD, 32'h0001_2318, 32'h0, 1'b1, 1'b0,
			32'hcafe_0001, 1'b0, 32'h0);
		add_row("store_word1", 1'b1, OP_STORE, 32'h0001_2314, 32'h1234_5678, 1'b1, 1'b0,
			32'h0, 1'b0, 32'h0);
		add_row("idle_gap", 1'b0, OP_LOAD, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("load_word0_kept", 1'b1, OP_LOAD, 32'h0001_2310, 32'h0, 1'b1, 1'b1,
			32'h0, 1'b0, 32'h0);
		add_row("load_word1_later", 1'b1, OP_LOAD, 32'h0001_2314, 32'h0, 1'b1, 1'b0,
			32'h1234_5678, 1'b0, 32'h0);
		// Store miss leaves the cache alone
		add_row("store_miss", 1'b1, OP_STORE, 32'h0002_2314, 32'hbad0_0000, 1'b0, 1'b0,
			32'h0, 1'b0, 32'h0);
		add_row("load_store_miss", 1'b1, OP_LOAD, 32'h0002_2314, 32'h0, 1'b0, 1'b0,
			32'h0, 1'b0, 32'h0);

		// Set 5 victims go 0 2 1 3 0 and line a is dirty when evicted
		add_row("fill_a", 1'b1, OP_FILL, 32'h000a_0050, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("store_a", 1'b1, OP_STORE, 32'h000a_0054, 32'hdead_beef, 1'b1, 1'b0,
			32'h0, 1'b0, 32'h0);
		add_row("fill_b", 1'b1, OP_FILL, 32'h000b_0050, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("fill_c", 1'b1, OP_FILL, 32'h000c_0050, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("fill_d", 1'b1, OP_FILL, 32'h000d_0050, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("fill_e", 1'b1, OP_FILL, 32'h000e_0050, 32'h0, 1'b0, 1'b0, 32'h0,
			1'b1, 32'h000a_0050);
		add_row("load_a_evicted", 1'b1, OP_LOAD, 32'h000a_0054, 32'h0, 1'b0, 1'b0,
			32'h0, 1'b0, 32'h0);
		add_row("load_b", 1'b1, OP_LOAD, 32'h000b_0058, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		add_row("load_c", 1'b1, OP_LOAD, 32'h000c_005c, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		add_row("load_d", 1'b1, OP_LOAD, 32'h000d_0050, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		add_row("load_e", 1'b1, OP_LOAD, 32'h000e_0054, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		// Loads leave way 2 as victim and line b is clean
		add_row("fill_f", 1'b1, OP_FILL, 32'h000f_0050, 32'h0, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0);
		add_row("load_b_evicted", 1'b1, OP_LOAD, 32'h000b_0058, 32'h0, 1'b0, 1'b0,
			32'h0, 1'b0, 32'h0);
		add_row("load_f", 1'b1, OP_LOAD, 32'h000f_0050, 32'h0, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
		// Word 1 of the set 1 line still holds the stored value and not the store miss data
		add_row("load_set1", 1'b1, OP_LOAD, 32'h0001_2314, 32'h0, 1'b1, 1'b0,
			32'h1234_5678, 1'b0, 32'h0);
	endtask

	// Drive one row and queue what it should produce
	task automatic apply_row(input test_row_t row);
		expect_t want;
		logic [31:0] line_addr;
		logic [CACHE_LINE_BITS-1:0] line;
		int word;

		line_addr = {row.addr[31:4], 4'h0};
		word = int'(row.addr[3:2]);
		line = '0;
		if (shadow_lines.exists(line_addr))
			line = shadow_lines[line_addr];

		want.name = row.name;
		want.valid = row.valid;
		want.op = row.op;
		want.exp_hit = row.exp_hit;
		want.check_data = row.op == OP_LOAD && row.exp_hit;
		want.exp_data = row.line_data ? line[word*WORD_BITS +: WORD_BITS] : row.exp_data;
		want.exp_wb = row.exp_wb;
		want.exp_wb_addr = row.exp_wb_addr;
		want.exp_wb_line = '0;
		// Victim contents as last written including stores
		if (row.exp_wb)
			want.exp_wb_line = shadow_lines[row.exp_wb_addr];

		request = '0;
		request.valid = row.valid;
		request.op = row.op;
		request.address.raw = row.addr;
		request.store_data = row.data;
		if (row.valid && row.op == OP_FILL)
		begin
			random_line(line);
			shadow_lines[line_addr] = line;
			request.fill_line = line;
		end
		else if (row.valid && row.op == OP_STORE && row.exp_hit)
		begin
			line[word*WORD_BITS +: WORD_BITS] = row.data;
			shadow_lines[line_addr] = line;
		end
		pending.push_back(want);
	endtask

	task automatic check_value(input string name, input string field,
		input logic [CACHE_LINE_BITS-1:0] expected, input logic [CACHE_LINE_BITS-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED %s %s expected %0h actual %0h", name, field, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Response mismatch");
		end
	endtask

	task automatic check_response(input expect_t want);
		check_value(want.name, "valid", want.valid, response.valid);
		if (want.valid)
		begin
			check_value(want.name, "op", want.op, response.op);
			check_value(want.name, "hit", want.exp_hit, response.hit);
			if (want.check_data)
				check_value(want.name, "load_data", want.exp_data, response.load_data);
			check_value(want.name, "writeback", want.exp_wb, response.writeback);
			if (want.exp_wb)
			begin
				check_value(want.name, "writeback_addr", want.exp_wb_addr,
					response.writeback_addr.raw);
				check_value(want.name, "writeback_line", want.exp_wb_line,
					response.writeback_line);
			end
		end
	endtask

	initial
	begin
		lfsr_state = 32'h7ad;
		table_ready = 1'b0;
		reset = 1'b1;
		request = '0;
		build_table();
		table_ready = 1'b1;

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (response.valid === 1'b0)
		else
		begin
			$display("Response valid is high right after reset");
			$display("Simulation failed");
			$fatal(1, "Reset check");
		end

		// Response of a row is stable three falling edges after it is driven
		foreach (rows[i])
		begin
			@(negedge clk);
			if (pending.size() == 3)
				check_response(pending.pop_front());
			apply_row(rows[i]);
		end

		// Drain the pipeline with idle cycles
		while (pending.size() > 0)
		begin
			@(negedge clk);
			check_response(pending.pop_front());
			request = '0;
		end

		$display("Simulation passed");
		$finish;
	end

	// Ten cycles per row plus margin for reset and drain
	initial
	begin
		wait (table_ready);
		repeat (rows.size() * 10 + 100) @(posedge clk);
		$display("Timeout, the stimulus table did not finish in time");
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end
endmodule

`default_nettype wire

// ==== verilog/cache_lru.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_lru(
	input logic clk,
	input logic reset,
	input logic access_en,
	input l2_types_pkg::l2_set_idx_t access_set,
	output l2_types_pkg::l2_way_idx_t victim_way,
	input logic update_en,
	input l2_types_pkg::l2_set_idx_t update_set,
	input l2_types_pkg::l2_way_idx_t update_way);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// Bit 0 is the root, bit 1 picks within ways 0-1, bit 2 within ways 2-3
	// A zero bit steers the victim toward the lower half
	logic [L2_SETS-1:0][LRU_BITS-1:0] tree_bits;
	logic [LRU_BITS-1:0] current_bits;
	logic [LRU_BITS-1:0] updated_bits;

	// Flip the nodes on the path so they point away from the used way
	function automatic logic [LRU_BITS-1:0] point_away(input logic [LRU_BITS-1:0] bits,
		input l2_way_idx_t way);
		logic [LRU_BITS-1:0] result;

		result = bits;
		result[0] = ~way[1];
		if (way[1])
			result[2] = ~way[0];
		else
			result[1] = ~way[0];

		return result;
	endfunction

	// Walk the tree from the root down to a leaf
	function automatic l2_way_idx_t pick_victim(input logic [LRU_BITS-1:0] bits);
		l2_way_idx_t way;

		if (bits[0])
			way = {1'b1, bits[2]};
		else
			way = {1'b0, bits[1]};

		return way;
	endfunction

	assign updated_bits = point_away(tree_bits[update_set], update_way);

	// Update landing on the set being looked up is visible right away
	always_comb
	begin
		if (update_en && update_set == access_set)
			current_bits = updated_bits;
		else
			current_bits = tree_bits[access_set];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tree_bits <= '0;
			victim_way <= '0;
		end
		else
		begin
			if (update_en)
				tree_bits[update_set] <= updated_bits;

			// Victim goes to the next stage together with the tags
			if (access_en)
				victim_way <= pick_victim(current_bits);
		end
	end
endmodule

`default_nettype wire

// ==== verilog/l2_cache_read.sv ====
`default_nettype none
`timescale 1ns/1ps

module l2_cache_read(
	input logic clk,
	input logic reset,

	// Lookup results from the tag stage
	input l2_types_pkg::l2req_packet_t tag_request,
	input logic [l2_config_pkg::L2_WAYS-1:0] way_valid,
	input l2_types_pkg::l2_tag_t [l2_config_pkg::L2_WAYS-1:0] way_tag,
	input logic [l2_config_pkg::L2_WAYS-1:0] way_dirty,
	input l2_types_pkg::l2_way_idx_t victim_way,

	// Metadata writes back to the tag stage
	output l2_types_pkg::l2_meta_update_t update,

	// Result to the requester
	output l2_types_pkg::l2_response_t response);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// Carried from the compare cycle into the data cycle
	typedef struct packed {
		logic valid;
		l2_op_t op;
		logic hit;
		l2_way_idx_t way;
		logic [WORD_IDX_BITS-1:0] word;
		l2_set_idx_t set_idx;
		logic [WORD_BITS-1:0] store_data;
		logic [CACHE_LINE_BITS-1:0] fill_line;
		logic writeback;
		l2_addr_u writeback_addr;
	} data_stage_t;

	// All ways of one set, split into words
	typedef logic [L2_WAYS-1:0][WORDS_PER_LINE-1:0][WORD_BITS-1:0] set_lines_t;

	l2_addr_u req_addr;
	logic [L2_WAYS-1:0] hit_ways;
	logic hit;
	l2_way_idx_t hit_way;
	logic is_load;
	logic is_store;
	logic is_fill;
	l2_addr_u wb_addr;
	data_stage_t data_next;
	data_stage_t data_stage;
	set_lines_t set_lines;
	set_lines_t new_lines;
	logic data_write_en;

	assign req_addr = tag_request.address;
	assign is_load = tag_request.valid && tag_request.op == OP_LOAD;
	assign is_store = tag_request.valid && tag_request.op == OP_STORE;
	assign is_fill = tag_request.valid && tag_request.op == OP_FILL;

	// Tag compare against every valid way
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < L2_WAYS; w++)
		begin
			hit_ways[w] = way_valid[w] && way_tag[w] == req_addr.fields.tag;
			if (hit_ways[w])
				hit_way = l2_way_idx_t'(w);
		end
	end

	assign hit = |hit_ways;

	// Metadata writes land at the next edge
	// Tag stage bypasses them for a request to the same set
	always_comb
	begin
		update = '0;
		update.tag_set = req_addr.fields.set_idx;
		update.tag_valid = 1'b1;
		update.tag_value = req_addr.fields.tag;
		update.dirty_set = req_addr.fields.set_idx;
		update.lru_set = req_addr.fields.set_idx;
		if (is_fill)
		begin
			// New line starts clean
			update.tag_en[victim_way] = 1'b1;
			update.dirty_en[victim_way] = 1'b1;
			update.dirty_value = 1'b0;
			update.lru_en = 1'b1;
			update.lru_way = victim_way;
		end
		else if (is_store && hit)
		begin
			update.dirty_en[hit_way] = 1'b1;
			update.dirty_value = 1'b1;
			update.lru_en = 1'b1;
			update.lru_way = hit_way;
		end
		else if (is_load && hit)
		begin
			update.lru_en = 1'b1;
			update.lru_way = hit_way;
		end
	end

	// Victim address rebuilt from its stored tag, word aligned to the line
	always_comb
	begin
		wb_addr = '0;
		wb_addr.fields.tag = way_tag[victim_way];
		wb_addr.fields.set_idx = req_addr.fields.set_idx;

		data_next.valid = tag_request.valid;
		data_next.op = tag_request.op;
		data_next.hit = hit;
		data_next.way = is_fill ? victim_way : hit_way;
		data_next.word = req_addr.fields.offset[OFFSET_BITS-1 -: WORD_IDX_BITS];
		data_next.set_idx = req_addr.fields.set_idx;
		data_next.store_data = tag_request.store_data;
		data_next.fill_line = tag_request.fill_line;
		data_next.writeback = is_fill && way_valid[victim_way] && way_dirty[victim_way];
		data_next.writeback_addr = wb_addr;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			data_stage <= '0;
		else
			data_stage <= data_next;
	end

	// Whole set is read during the compare cycle and rewritten in the data cycle
	// A write to the set being read is forwarded by the memory
	sram_1r1w #(.DATA_WIDTH(CACHE_LINE_BITS * L2_WAYS), .SIZE(L2_SETS)) data_ram(
		.clk,
		.reset,
		.read_en(tag_request.valid),
		.read_addr(req_addr.fields.set_idx),
		.read_data(set_lines),
		.write_en(data_write_en),
		.write_addr(data_stage.set_idx),
		.write_data(new_lines));

	// Merge the fill line or the store word into the set
	always_comb
	begin
		new_lines = set_lines;
		data_write_en = 1'b0;
		if (data_stage.valid && data_stage.op == OP_FILL)
		begin
			new_lines[data_stage.way] = data_stage.fill_line;
			data_write_en = 1'b1;
		end
		else if (data_stage.valid && data_stage.op == OP_STORE && data_stage.hit)
		begin
			new_lines[data_stage.way][data_stage.word] = data_stage.store_data;
			data_write_en = 1'b1;
		end
	end

	// Response registered two edges after the tag lookup
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			response <= '0;
		else
		begin
			response.valid <= data_stage.valid;
			response.op <= data_stage.op;
			response.hit <= data_stage.hit;
			response.load_data <= set_lines[data_stage.way][data_stage.word];
			response.writeback <= data_stage.writeback;
			response.writeback_addr <= data_stage.writeback_addr;
			// Old victim contents, read before the fill overwrites them
			response.writeback_line <= set_lines[data_stage.way];
		end
	end

	// Tag stage never leaves two valid copies of a line in one set
	assert property (@(posedge clk) disable iff (reset) tag_request.valid |-> $onehot0(hit_ways))
		else $error("multiple ways hit");
	// Requester only fills after a miss
	assert property (@(posedge clk) disable iff (reset) is_fill |-> !hit)
		else $error("fill matches a resident tag");
endmodule

`default_nettype wire

// ==== verilog/l2_cache_tag.sv ====
`default_nettype none
`timescale 1ns/1ps

module l2_cache_tag(
	input logic clk,
	input logic reset,

	// Request from the requester
	input l2_types_pkg::l2req_packet_t request,

	// Metadata writes from the read stage
	input l2_types_pkg::l2_meta_update_t update,

	// Lookup results for the read stage
	output l2_types_pkg::l2req_packet_t tag_request,
	output logic [l2_config_pkg::L2_WAYS-1:0] way_valid,
	output l2_types_pkg::l2_tag_t [l2_config_pkg::L2_WAYS-1:0] way_tag,
	output logic [l2_config_pkg::L2_WAYS-1:0] way_dirty,
	output l2_types_pkg::l2_way_idx_t victim_way);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	l2_set_idx_t request_set;
	logic [L2_WAYS-1:0][L2_SETS-1:0] line_valid;
	logic [L2_WAYS-1:0] next_valid;

	assign request_set = request.address.fields.set_idx;

	// Pseudo-LRU state, victim comes out one cycle later
	cache_lru lru(
		.clk,
		.reset,
		.access_en(request.valid),
		.access_set(request_set),
		.victim_way,
		.update_en(update.lru_en),
		.update_set(update.lru_set),
		.update_way(update.lru_way));

	// Tag and dirty memories, one pair per way
	// Both bypass a same-set write internally
	for (genvar way = 0; way < L2_WAYS; way++)
	begin : way_meta
		sram_1r1w #(.DATA_WIDTH(TAG_BITS), .SIZE(L2_SETS)) tag_ram(
			.clk,
			.reset,
			.read_en(request.valid),
			.read_addr(request_set),
			.read_data(way_tag[way]),
			.write_en(update.tag_en[way]),
			.write_addr(update.tag_set),
			.write_data(update.tag_value));

		sram_1r1w #(.DATA_WIDTH(1), .SIZE(L2_SETS)) dirty_ram(
			.clk,
			.reset,
			.read_en(request.valid),
			.read_addr(request_set),
			.read_data(way_dirty[way]),
			.write_en(update.dirty_en[way]),
			.write_addr(update.dirty_set),
			.write_data(update.dirty_value));
	end

	// Valid bits live in flops so reset can clear them
	// Pending tag write to the same set overrides the stored bit
	always_comb
	begin
		for (int w = 0; w < L2_WAYS; w++)
		begin
			if (update.tag_en[w] && update.tag_set == request_set)
				next_valid[w] = update.tag_valid;
			else
				next_valid[w] = line_valid[w][request_set];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			line_valid <= '0;
			way_valid <= '0;
			tag_request <= '0;
		end
		else
		begin
			for (int w = 0; w < L2_WAYS; w++)
			begin
				if (update.tag_en[w])
					line_valid[w][update.tag_set] <= update.tag_valid;
			end

			if (request.valid)
				way_valid <= next_valid;

			// Request follows its lookup results into the read stage
			tag_request <= request;
		end
	end
endmodule

`default_nettype wire

// ==== verilog/l2_cache_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module l2_cache_top(
	input logic clk,
	input logic reset,
	input l2_types_pkg::l2req_packet_t request,
	output l2_types_pkg::l2_response_t response);

	import l2_config_pkg::*;
	import l2_types_pkg::*;

	// Tag stage to read stage
	l2req_packet_t tag_request;
	logic [L2_WAYS-1:0] way_valid;
	l2_tag_t [L2_WAYS-1:0] way_tag;
	logic [L2_WAYS-1:0] way_dirty;
	l2_way_idx_t victim_way;

	// Read stage back to tag stage
	l2_meta_update_t update;

	l2_cache_tag tag_stage(
		.clk,
		.reset,
		.request,
		.update,
		.tag_request,
		.way_valid,
		.way_tag,
		.way_dirty,
		.victim_way);

	l2_cache_read read_stage(
		.clk,
		.reset,
		.tag_request,
		.way_valid,
		.way_tag,
		.way_dirty,
		.victim_way,
		.update,
		.response);
endmodule

`default_nettype wire

// ==== verilog/l2_config_pkg.sv ====
`default_nettype none

package l2_config_pkg;
	// Cache geometry
	localparam int L2_WAYS = 4;
	localparam int L2_SETS = 16;
	localparam int WORDS_PER_LINE = 4;

	// Data widths
	localparam int WORD_BITS = 32;
	localparam int CACHE_LINE_BITS = WORDS_PER_LINE * WORD_BITS;
	localparam int ADDR_BITS = 32;

	// Address split and index widths
	localparam int SET_IDX_BITS = 4;
	localparam int WAY_IDX_BITS = 2;
	localparam int WORD_IDX_BITS = 2;
	localparam int OFFSET_BITS = 4;
	localparam int TAG_BITS = ADDR_BITS - SET_IDX_BITS - OFFSET_BITS;

	// One tree bit per internal node of the way tree
	localparam int LRU_BITS = L2_WAYS - 1;
endpackage

`default_nettype wire

// ==== verilog/l2_types_pkg.sv ====
`default_nettype none

package l2_types_pkg;
	import l2_config_pkg::*;

	typedef logic [TAG_BITS-1:0] l2_tag_t;
	typedef logic [SET_IDX_BITS-1:0] l2_set_idx_t;
	typedef logic [WAY_IDX_BITS-1:0] l2_way_idx_t;

	// Same 32 bits, either as a plain word or split into fields
	// Offset bits 3:2 pick the word, bits 1:0 are ignored
	typedef union packed {
		logic [ADDR_BITS-1:0] raw;
		struct packed {
			l2_tag_t tag;
			l2_set_idx_t set_idx;
			logic [OFFSET_BITS-1:0] offset;
		} fields;
	} l2_addr_u;

	typedef enum logic [1:0] {
		OP_LOAD = 2'd0,
		OP_STORE = 2'd1,
		OP_FILL = 2'd2
	} l2_op_t;

	// Request from the requester, one per clock when valid
	typedef struct packed {
		logic valid;
		l2_op_t op;
		l2_addr_u address;
		logic [WORD_BITS-1:0] store_data;
		logic [CACHE_LINE_BITS-1:0] fill_line;
	} l2req_packet_t;

	// Result back to the requester, plus write-back of a dirty victim
	typedef struct packed {
		logic valid;
		l2_op_t op;
		logic hit;
		logic [WORD_BITS-1:0] load_data;
		logic writeback;
		l2_addr_u writeback_addr;
		logic [CACHE_LINE_BITS-1:0] writeback_line;
	} l2_response_t;

	// Metadata writes from the read stage into the tag stage
	typedef struct packed {
		logic [L2_WAYS-1:0] tag_en;
		l2_set_idx_t tag_set;
		logic tag_valid;
		l2_tag_t tag_value;
		logic [L2_WAYS-1:0] dirty_en;
		l2_set_idx_t dirty_set;
		logic dirty_value;
		logic lru_en;
		l2_set_idx_t lru_set;
		l2_way_idx_t lru_way;
	} l2_meta_update_t;
endpackage

`default_nettype wire

// ==== verilog/sram_1r1w.sv ====
`default_nettype none
`timescale 1ns/1ps

module sram_1r1w
	#(parameter int DATA_WIDTH = 32,
	parameter int SIZE = 64)
	(input logic clk,
	input logic reset,
	input logic read_en,
	input logic [$clog2(SIZE)-1:0] read_addr,
	output logic [DATA_WIDTH-1:0] read_data,
	input logic write_en,
	input logic [$clog2(SIZE)-1:0] write_addr,
	input logic [DATA_WIDTH-1:0] write_data);

	logic [DATA_WIDTH-1:0] data [SIZE];

	always_ff @(posedge clk)
	begin
		if (write_en)
			data[write_addr] <= write_data;

		// Output holds its last value when no read is issued
		if (read_en)
		begin
			// Same-cycle write wins over the stored word
			if (write_en && write_addr == read_addr)
				read_data <= write_data;
			else
				read_data <= data[read_addr];
		end
	end

	assert property (@(posedge clk) disable iff (reset) read_en |-> read_addr < SIZE)
		else $error("sram_1r1w read address out of range");
	assert property (@(posedge clk) disable iff (reset) write_en |-> write_addr < SIZE)
		else $error("sram_1r1w write address out of range");
endmodule

`default_nettype wire
